//--- Makefile
TOP = knight_drive_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f knight_drive.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- knight_drive.f
+incdir+source
source/drive_pkg.sv
source/heading_err.sv
source/move_ctrl.sv
source/frwrd_ramp.sv
source/pid.sv
source/mtr_pwm.sv
source/knight_drive.sv
verification/knight_drive_tb.sv

//--- source/drive_params.svh
// Drive constants for the PID gains, forward ramp and PWM resolution.
`ifndef DRIVE_PARAMS_SVH
`define DRIVE_PARAMS_SVH

// Loop gains. Both are positive, sign bit is clear.
`define P_COEFF    6'h10
`define D_COEFF    5'h07

// Forward ramp.
`define FRWRD_INC  10'h020  // Step per heading sample.
`define FAST_SPEED 10'h2C0  // Cruise speed, a whole number of steps.

// Motor drive.
`define PWM_W      10       // Counter width, matches the speed magnitude.

`endif

//--- source/drive_pkg.sv
// Drive types package holding the heading, error, speed and move state types.
`default_nettype none

package drive_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath words.
  ////////////////////////////////////////////////////////////////////////////
  typedef logic signed [11:0] hdng_t;   // Heading from gyro or command.
  typedef logic signed [11:0] err_t;    // Heading error, wraps like the heading.
  typedef logic [9:0]         frwrd_t;  // Forward speed, never negative.
  typedef logic signed [10:0] spd_t;    // Wheel speed, sign gives direction.

  ////////////////////////////////////////////////////////////////////////////
  // Move sequencer states.
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE      = 2'd0,  // Parked, PID held off.
    RAMP_UP   = 2'd1,  // Forward speed climbing.
    CRUISE    = 2'd2,  // At top speed.
    RAMP_DOWN = 2'd3   // Slowing to a stop.
  } mv_state_t;

endpackage

`default_nettype wire

//--- source/frwrd_ramp.sv
// Forward speed ramp that steps up or down on each heading sample and flags its limits.
`timescale 1ns/100ps
`default_nettype none
`include "drive_params.svh"

module frwrd_ramp import drive_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   err_vld,    // Step timing, one per sample.
  input  logic   ramp_up,
  input  logic   ramp_down,
  output frwrd_t frwrd,
  output logic   at_max,
  output logic   at_zero
);

  logic [10:0] up_sum;  // Extra bit catches the carry.
  logic [10:0] dn_dif;  // Extra bit catches the borrow.

  assign up_sum = {1'b0, frwrd} + {1'b0, `FRWRD_INC};
  assign dn_dif = {1'b0, frwrd} - {1'b0, `FRWRD_INC};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) frwrd <= '0;
    else if (err_vld) begin
      if (ramp_up)
        frwrd <= (up_sum > {1'b0, `FAST_SPEED}) ? `FAST_SPEED : up_sum[9:0];  // Clamp high.
      else if (ramp_down)
        frwrd <= dn_dif[10] ? '0 : dn_dif[9:0];  // Borrow means below zero.
    end
  end

  assign at_max  = (frwrd == `FAST_SPEED);
  assign at_zero = (frwrd == '0);

  frwrd_ceiling: assert property (@(posedge clk) disable iff (!rst_n) frwrd <= `FAST_SPEED)
    else $error("frwrd above FAST_SPEED.");

endmodule

`default_nettype wire

//--- source/heading_err.sv
// Heading error stage that forms the wrapped heading difference on every gyro sample.
`timescale 1ns/100ps
`default_nettype none

module heading_err import drive_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  strt_mv,    // Load a new desired heading.
  input  hdng_t dsrd_hdng,
  input  logic  hdng_vld,   // New gyro sample.
  input  hdng_t actl_hdng,
  output logic  err_vld,    // One cycle per sample.
  output err_t  error
);

  hdng_t dsrd_q;  // Heading held for the whole move.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dsrd_q  <= '0;
      error   <= '0;
      err_vld <= 1'b0;
    end else begin
      if (strt_mv) dsrd_q <= dsrd_hdng;          // Old value still used this cycle.
      if (hdng_vld) error <= actl_hdng - dsrd_q;  // 12-bit wrap keeps +-180 degrees.
      err_vld <= hdng_vld;
    end
  end

  // Gyro strobes are single pulses, so the error strobe is too.
  err_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n) err_vld |=> !err_vld)
    else $error("err_vld held for two cycles.");

endmodule

`default_nettype wire

//--- source/knight_drive.sv
// Drive top level tying the move sequencer to the heading, ramp, PID and motor blocks.
`timescale 1ns/100ps
`default_nettype none

module knight_drive import drive_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  strt_mv,
  input  logic  stp_mv,
  input  logic  hdng_vld,
  input  hdng_t dsrd_hdng,
  input  hdng_t actl_hdng,
  output logic  moving,     // Telemetry and PID enable.
  output spd_t  lft_spd,    // Telemetry.
  output spd_t  rght_spd,   // Telemetry.
  output logic  lft_dir,
  output logic  lft_pwm,
  output logic  rght_dir,
  output logic  rght_pwm
);

  logic   err_vld;
  err_t   error;
  logic   ramp_up, ramp_down;
  frwrd_t frwrd;
  logic   at_max, at_zero;

  heading_err heading_err_i (.clk, .rst_n, .strt_mv, .dsrd_hdng, .hdng_vld, .actl_hdng,
                             .err_vld, .error);

  move_ctrl move_ctrl_i (.clk, .rst_n, .strt_mv, .stp_mv, .at_max, .at_zero,
                         .moving, .ramp_up, .ramp_down);

  frwrd_ramp frwrd_ramp_i (.clk, .rst_n, .err_vld, .ramp_up, .ramp_down,
                           .frwrd, .at_max, .at_zero);

  pid pid_i (.clk, .rst_n, .moving, .err_vld, .error, .frwrd, .lft_spd, .rght_spd);

  // One motor drive per wheel.
  mtr_pwm lft_mtr_i  (.clk, .rst_n, .spd(lft_spd),  .dir(lft_dir),  .pwm(lft_pwm));
  mtr_pwm rght_mtr_i (.clk, .rst_n, .spd(rght_spd), .dir(rght_dir), .pwm(rght_pwm));

endmodule

`default_nettype wire

//--- source/move_ctrl.sv
// Move sequencer FSM stepping through idle, ramp up, cruise and ramp down.
`timescale 1ns/100ps
`default_nettype none

module move_ctrl import drive_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic strt_mv,    // Start a move.
  input  logic stp_mv,     // End the move.
  input  logic at_max,     // Forward speed at the ceiling.
  input  logic at_zero,    // Forward speed back to zero.
  output logic moving,     // Enables the PID.
  output logic ramp_up,    // Forward register counts up.
  output logic ramp_down   // Forward register counts down.
);

  mv_state_t state, nxt_state;

  ////////////////////////////////////////////////////////////////////////////
  // State register.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= IDLE;
    else        state <= nxt_state;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state. A stop wins over reaching top speed.
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (strt_mv) nxt_state = RAMP_UP;
      end
      RAMP_UP: begin
        if (stp_mv)      nxt_state = RAMP_DOWN;
        else if (at_max) nxt_state = CRUISE;
      end
      CRUISE: begin
        if (stp_mv) nxt_state = RAMP_DOWN;
      end
      RAMP_DOWN: begin
        if (at_zero) nxt_state = IDLE;  // Robot has stopped.
      end
      default: nxt_state = IDLE;
    endcase
  end

  // Outputs decode straight from the state.
  assign moving    = (state != IDLE);
  assign ramp_up   = (state == RAMP_UP);
  assign ramp_down = (state == RAMP_DOWN);

  // A parked robot has no forward speed left.
  parked_at_zero: assert property (@(posedge clk) disable iff (!rst_n) !moving |-> at_zero)
    else $error("moving low while forward speed is not zero.");

  // The robot is parked when it comes out of reset.
  idle_after_rst: assert property (@(posedge clk) $rose(rst_n) |-> !moving)
    else $error("moving high after reset release.");

endmodule

`default_nettype wire

//--- source/mtr_pwm.sv
// Motor drive that turns a signed wheel speed into a direction bit and a PWM level.
`timescale 1ns/100ps
`default_nettype none
`include "drive_params.svh"

module mtr_pwm import drive_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  spd_t spd,   // Signed wheel speed.
  output logic dir,   // High for reverse.
  output logic pwm    // Registered drive level.
);

  logic [10:0]       mag_full;  // Holds 1024 for the most negative speed.
  logic [`PWM_W-1:0] mag;       // Duty clamped to counter range.
  logic [`PWM_W-1:0] cnt;       // Free-running PWM period counter.

  ////////////////////////////////////////////////////////////////////////////
  // Magnitude.
  ////////////////////////////////////////////////////////////////////////////
  assign mag_full = spd[10] ? 11'(-spd) : 11'(spd);
  assign mag      = mag_full[10] ? '1 : mag_full[`PWM_W-1:0];  // Clamp to full duty.

  ////////////////////////////////////////////////////////////////////////////
  // Counter and outputs.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cnt <= '0;
    else        cnt <= cnt + 1'b1;  // Wraps every period.
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dir <= 1'b0;
      pwm <= 1'b0;
    end else begin
      dir <= spd[10];
      pwm <= (cnt < mag);  // High for mag counts of each period.
    end
  end

endmodule

`default_nettype wire

//--- source/pid.sv
// Heading PID that trims the forward speed into left and right wheel speeds.
`timescale 1ns/100ps
`default_nettype none
`include "drive_params.svh"

module pid import drive_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   moving,     // Loop active, else speeds zero.
  input  logic   err_vld,    // New error sample.
  input  err_t   error,
  input  frwrd_t frwrd,
  output spd_t   lft_spd,
  output spd_t   rght_spd
);

  logic signed [9:0]  err_sat;                 // Error clipped to 10 bits.
  logic signed [13:0] p_term;
  logic signed [14:0] err_ext, sum;            // Integrator operand and result.
  logic signed [14:0] integrator, nxt_integrator;
  logic               ov;                      // Signed overflow of the add.
  logic signed [8:0]  i_term;
  logic signed [9:0]  stage1, stage2, prev_err; // Error history, newest first.
  logic signed [10:0] d_diff;                  // Full range, no wrap.
  logic signed [7:0]  d_sat;
  logic signed [12:0] d_term;
  logic signed [13:0] p_ext, i_ext, d_ext, pid_term;
  spd_t               frwrd_ext, raw_lft, raw_rght;

  ////////////////////////////////////////////////////////////////////////////
  // Proportional term.
  ////////////////////////////////////////////////////////////////////////////
  assign err_sat = (!error[11] && |error[10:9])  ? 10'h1FF :  // Large positive.
                   (error[11] && !(&error[10:9])) ? 10'h200 :  // Large negative.
                   error[9:0];

  assign p_term = err_sat * $signed(`P_COEFF);

  ////////////////////////////////////////////////////////////////////////////
  // Integral term.
  ////////////////////////////////////////////////////////////////////////////
  assign err_ext = {{5{err_sat[9]}}, err_sat};
  assign sum     = err_ext + integrator;

  // Same input signs and a flipped result sign.
  assign ov = ~(err_ext[14] ^ integrator[14]) & (err_ext[14] ^ sum[14]);

  // Hold on overflow, clear while parked.
  assign nxt_integrator = !moving          ? '0  :
                          (err_vld && !ov) ? sum :
                          integrator;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) integrator <= '0;
    else        integrator <= nxt_integrator;
  end

  assign i_term = integrator[14:6];

  ////////////////////////////////////////////////////////////////////////////
  // Derivative term against the error three samples back.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage1   <= '0;
      stage2   <= '0;
      prev_err <= '0;
    end else if (err_vld) begin
      stage1   <= err_sat;
      stage2   <= stage1;
      prev_err <= stage2;
    end
  end

  assign d_diff = err_sat - prev_err;
  assign d_sat  = (!d_diff[10] && |d_diff[9:7])  ? 8'h7F :
                  (d_diff[10] && !(&d_diff[9:7])) ? 8'h80 :
                  d_diff[7:0];
  assign d_term = d_sat * $signed(`D_COEFF);

  ////////////////////////////////////////////////////////////////////////////
  // Sum and wheel speeds.
  ////////////////////////////////////////////////////////////////////////////
  assign p_ext    = {p_term[13], p_term[13:1]};  // P is halved.
  assign i_ext    = {{5{i_term[8]}}, i_term};
  assign d_ext    = {d_term[12], d_term};
  assign pid_term = p_ext + i_ext + d_ext;

  assign frwrd_ext = spd_t'({1'b0, frwrd});
  assign raw_lft   = frwrd_ext + pid_term[13:3];
  assign raw_rght  = frwrd_ext - pid_term[13:3];

  // A sign flip against the trim direction is a wrap, so pin at full speed.
  assign lft_spd  = !moving ? '0 :
                    (~pid_term[13] & raw_lft[10])  ? 11'h3FF : raw_lft;
  assign rght_spd = !moving ? '0 :
                    (pid_term[13] & raw_rght[10])  ? 11'h3FF : raw_rght;

endmodule

`default_nettype wire

//--- verification/knight_drive_tb.sv
// Drive subsystem testbench that checks random heading runs against a cycle model.
`timescale 1ns/100ps
`default_nettype none
`include "drive_params.svh"

module knight_drive_tb import drive_pkg::*; ();

  logic  clk, rst_n;
  logic  strt_mv, stp_mv, hdng_vld;
  hdng_t dsrd_hdng, actl_hdng;
  logic  moving, lft_dir, lft_pwm, rght_dir, rght_pwm;
  spd_t  lft_spd, rght_spd;

  logic [31:0] rng = 32'd52;  // Xorshift state.
  int          gap = 5;       // Cycles to the next gyro sample.
  int          samples = 0;   // Gyro samples issued so far.
  int          bias = 0;      // Offset of the gyro heading from the desired heading.

  // Model registers.
  int        m_dsrd, m_err, m_frwrd, m_integ, m_h1, m_h2, m_h3, m_cnt;
  logic      m_vld, m_ldir, m_lpwm, m_rdir, m_rpwm;
  mv_state_t m_state;

  knight_drive knight_drive_i (.clk, .rst_n, .strt_mv, .stp_mv, .hdng_vld, .dsrd_hdng,
                               .actl_hdng, .moving, .lft_spd, .rght_spd, .lft_dir,
                               .lft_pwm, .rght_dir, .rght_pwm);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz.
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int clip(input int x, input int lo, input int hi);
    return (x < lo) ? lo : (x > hi) ? hi : x;
  endfunction

  function automatic int wrap_heading(input int x);
    int y;
    y = x & 'hFFF;            // Keep 12 bits.
    if (y > 2047) y -= 4096;  // Back to signed.
    return y;
  endfunction

  // Wheel speed from the model registers and a given integrator value.
  function automatic int wheel_speed(input logic left, input int integ);
    int e, d, trim, s;
    e    = clip(m_err, -512, 511);
    d    = clip(e - m_h3, -128, 127) * int'(`D_COEFF);
    trim = ((e * int'(`P_COEFF)) >>> 1) + (integ >>> 6) + d;
    trim = trim >>> 3;  // Upper bits of the sum.
    s    = left ? m_frwrd + trim : m_frwrd - trim;
    if (m_state == IDLE) return 0;
    return (s > 1023) ? 1023 : s;  // Overshoot pins at full speed.
  endfunction

  function automatic int duty(input int s);
    return clip((s < 0) ? -s : s, 0, 1023);
  endfunction

  task automatic check(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Output mismatch.");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "Wait timed out.");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model.
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin : model
    int e_sat, s, l, r;
    if (!rst_n) begin
      m_dsrd  <= 0;
      m_err   <= 0;
      m_vld   <= 1'b0;
      m_state <= IDLE;
      m_frwrd <= 0;
      m_integ <= 0;
      m_h1    <= 0;
      m_h2    <= 0;
      m_h3    <= 0;
      m_cnt   <= 0;
      m_ldir  <= 1'b0;
      m_lpwm  <= 1'b0;
      m_rdir  <= 1'b0;
      m_rpwm  <= 1'b0;
    end else begin
      e_sat = clip(m_err, -512, 511);
      s     = m_integ + e_sat;
      l     = wheel_speed(1'b1, m_integ);
      r     = wheel_speed(1'b0, m_integ);
      if (strt_mv) m_dsrd <= dsrd_hdng;
      if (hdng_vld) m_err <= wrap_heading(actl_hdng - m_dsrd);
      m_vld <= hdng_vld;
      case (m_state)
        IDLE:      if (strt_mv) m_state <= RAMP_UP;
        RAMP_UP:   if (stp_mv) m_state <= RAMP_DOWN;
                   else if (m_frwrd == `FAST_SPEED) m_state <= CRUISE;
        CRUISE:    if (stp_mv) m_state <= RAMP_DOWN;
        RAMP_DOWN: if (m_frwrd == 0) m_state <= IDLE;
      endcase
      if (m_vld && m_state == RAMP_UP) m_frwrd <= clip(m_frwrd + `FRWRD_INC, 0, `FAST_SPEED);
      if (m_vld && m_state == RAMP_DOWN) m_frwrd <= clip(m_frwrd - `FRWRD_INC, 0, `FAST_SPEED);
      if (m_state == IDLE) m_integ <= 0;  // Cleared while parked.
      else if (m_vld && s >= -16384 && s <= 16383) m_integ <= s;  // Holds on overflow.
      if (m_vld) begin
        m_h1 <= e_sat;
        m_h2 <= m_h1;
        m_h3 <= m_h2;
      end
      m_cnt  <= (m_cnt + 1) % 1024;
      m_ldir <= (l < 0);
      m_lpwm <= (m_cnt < duty(l));
      m_rdir <= (r < 0);
      m_rpwm <= (m_cnt < duty(r));
    end
  end

  // Outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      check("moving", moving, int'(m_state != IDLE));
      check("lft_spd", lft_spd, wheel_speed(1'b1, m_integ));
      check("rght_spd", rght_spd, wheel_speed(1'b0, m_integ));
      check("lft_dir", lft_dir, m_ldir);
      check("lft_pwm", lft_pwm, m_lpwm);
      check("rght_dir", rght_dir, m_rdir);
      check("rght_pwm", rght_pwm, m_rpwm);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus.
  ////////////////////////////////////////////////////////////////////////////
  task automatic step(input logic do_strt, input logic do_stp);
    @(posedge clk);
    strt_mv  <= do_strt;
    stp_mv   <= do_stp;
    hdng_vld <= 1'b0;
    if (do_strt) begin
      rng = xorshift(rng);
      dsrd_hdng <= rng[11:0];
    end
    gap = gap - 1;
    if (gap <= 0) begin  // Gyro sample due.
      rng = xorshift(rng);
      hdng_vld <= 1'b1;
      if (rng[31] && bias == 0) actl_hdng <= rng[11:0];  // Any heading gives large errors.
      else actl_hdng <= dsrd_hdng + hdng_t'(bias + int'(rng[17:12]) - 32);
      gap = 3 + int'(rng[22:20]);
      samples++;
    end
    @(negedge clk);
  endtask

  task automatic run_samples(input int n);
    int start, cycles;
    start  = samples;
    cycles = 0;
    while (samples - start < n) begin
      step(1'b0, 1'b0);
      cycles++;
      if (cycles > 12 * n) abort_on_timeout("gyro samples stopped arriving");
    end
  endtask

  task automatic wait_top_speed();
    int start;
    start = samples;
    while (m_frwrd != `FAST_SPEED) begin
      step(1'b0, 1'b0);
      if (samples - start > 30) abort_on_timeout("forward speed never reached the top");
    end
  endtask

  task automatic wait_parked();
    int start;
    start = samples;
    while (moving) begin
      step(1'b0, 1'b0);
      if (samples - start > 30) abort_on_timeout("robot never came to a stop");
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    strt_mv   = 1'b0;
    stp_mv    = 1'b0;
    hdng_vld  = 1'b0;
    dsrd_hdng = '0;
    actl_hdng = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    repeat (20) step(1'b0, 1'b0);  // Samples still arrive while parked.
    check("moving", moving, 0);
    check("lft_spd", lft_spd, 0);
    check("rght_spd", rght_spd, 0);
    check("lft_pwm", lft_pwm, 0);
    check("rght_pwm", rght_pwm, 0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    check("moving", moving, 1);  // One edge after the start strobe.
    wait_top_speed();
    bias = 700;  // Saturate error and integrator upward.
    run_samples(60);
    bias = -700;  // Long enough to reach the lower integrator limit.
    run_samples(100);
    bias = 0;
    run_samples(400);
    step(1'b0, 1'b1);
    wait_parked();
    rng = xorshift(rng);
    repeat (1 + int'(rng[3:0])) step(1'b0, 1'b0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    check("moving", moving, 1);
    check("lft_spd", lft_spd, wheel_speed(1'b1, 0));  // Integral term starts at zero.
    check("rght_spd", rght_spd, wheel_speed(1'b0, 0));
    wait_top_speed();
    run_samples(50);
    step(1'b0, 1'b1);
    wait_parked();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
